/* flist.f */
+incdir+include
hw/alu_pkg.sv
hw/alu_arith_unit.sv
hw/alu_logic_shift_unit.sv
hw/alu_result_select.sv
hw/alu_apb_regs.sv
hw/alu_apb_top.sv
testbench/alu_tb.sv

/* testbench/alu_tb.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_tb;

  localparam int TIMEOUT = 20;

  logic                   clk = 1'b0;
  logic                   arst_n;
  logic [`ALU_APB_AW-1:0] paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`ALU_APB_DW-1:0] pwdata;
  wire  [`ALU_APB_DW-1:0] prdata;
  wire                    pready;
  wire                    pslverr;
  logic [`ALU_APB_DW-1:0] rdata;
  logic                   rerr;
  logic [15:0]            edge_vals [4] = '{16'h7FFF, 16'h8000, 16'hFFFF, 16'h0000};

  alu_apb_top DUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  always #4 clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
      $display("Verification failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB master
  ////////////////////////////////////////////////////////////////////////////

  task automatic apb_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] data);
    int cycles;
    cycles = 0;
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    #2;
    // No pready outside the access phase
    check_eq("pready", pready, 1'b0);
    @(posedge clk);
    #1;
    penable = 1'b1;
    #2;
    while (!pready) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        $display("pready did not rise within %0d cycles of the access phase", TIMEOUT);
        $display("Verification failed");
        $fatal(1, "APB handshake timeout");
      end
      @(posedge clk);
      #3;
    end
    rdata = prdata;
    rerr  = pslverr;
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    apb_transfer(1'b1, addr, data);
  endtask

  task automatic apb_read(input logic [7:0] addr);
    apb_transfer(1'b0, addr, 32'h0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model returning {overflow, result}
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [16:0] alu_model(input logic [3:0] op, input logic [15:0] a,
                                            input logic [15:0] b);
    int          sa;
    int          sb;
    int          amt;
    int          idx;
    longint      wide;
    logic        use_wide;
    logic [15:0] res;
    sa       = $signed(a);
    sb       = $signed(b);
    amt      = b;
    wide     = 0;
    use_wide = 1'b1;
    res      = 16'h0;
    case (op)
      alu_pkg::OP_SUB: wide = sa - sb;
      alu_pkg::OP_ADD: wide = sa + sb;
      alu_pkg::OP_DEC: wide = sa - 1;
      alu_pkg::OP_INC: wide = sa + 1;
      alu_pkg::OP_SLA: begin
        // a * 2^b capped once it cannot fit any more
        wide = sa;
        for (idx = 0; idx < amt && idx < 17; idx++)
          wide = wide * 2;
      end
      default: use_wide = 1'b0;
    endcase
    case (op)
      alu_pkg::OP_OR:  res = a | b;
      alu_pkg::OP_AND: res = a & b;
      alu_pkg::OP_INV: res = ~a;
      alu_pkg::OP_SLE: res = (sa <= sb) ? 16'h1 : 16'h0;
      alu_pkg::OP_SRA:
        for (idx = 0; idx < 16; idx++)
          res[idx] = (idx + amt < 16) ? a[idx+amt] : a[15];
      alu_pkg::OP_SLL:
        for (idx = 0; idx < 16; idx++)
          res[idx] = (idx >= amt) ? a[idx-amt] : 1'b0;
      alu_pkg::OP_SRL:
        for (idx = 0; idx < 16; idx++)
          res[idx] = (idx + amt < 16) ? a[idx+amt] : 1'b0;
      default: ;
    endcase
    if (use_wide)
      return {(wide > 32767 || wide < -32768), wide[15:0]};
    return {1'b0, res};
  endfunction

  task automatic run_op(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b);
    logic [16:0] exp;
    apb_write(`ALU_REG_A, {16'h0, a});
    apb_write(`ALU_REG_B, {16'h0, b});
    apb_write(`ALU_REG_CTRL, {28'h0, op});
    apb_read(`ALU_REG_STATUS);
    exp = alu_model(op, a, b);
    check_eq("pslverr", rerr, 1'b0);
    check_eq($sformatf("status op %0d a %h b %h", op, a, b), rdata,
             {1'b1, 13'h0, exp[15:0] == 16'h0, exp});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_and_valid();
    apb_read(`ALU_REG_STATUS);
    check_eq("status after reset", rdata, 32'h0);
    run_op(alu_pkg::OP_ADD, 16'h0003, 16'h0004);
    apb_write(`ALU_REG_A, 32'h0011);
    apb_read(`ALU_REG_STATUS);
    check_eq("status.valid", rdata[31], 1'b0);
  endtask

  task automatic arith_ops();
    logic [3:0]  ops [4] = '{alu_pkg::OP_ADD, alu_pkg::OP_SUB, alu_pkg::OP_INC, alu_pkg::OP_DEC};
    logic [15:0] a;
    logic [15:0] b;
    for (int i = 0; i < 4; i++)
      for (int j = 0; j < 4; j++)
        for (int k = 0; k < 4; k++)
          run_op(ops[k], edge_vals[i], edge_vals[j]);
    repeat (20) begin
      a = $urandom;
      b = $urandom;
      for (int k = 0; k < 4; k++)
        run_op(ops[k], a, b);
    end
  endtask

  task automatic logic_and_compare();
    logic [3:0]  ops [4] = '{alu_pkg::OP_AND, alu_pkg::OP_OR, alu_pkg::OP_INV, alu_pkg::OP_SLE};
    // Equal operands, mixed signs and both signs negative
    logic [15:0] va [6] = '{16'h1234, 16'h8000, 16'h7FFF, 16'hFFFF, 16'hA5A5, 16'hFFFE};
    logic [15:0] vb [6] = '{16'h1234, 16'h7FFF, 16'h8000, 16'h0001, 16'h5A5A, 16'hFFFF};
    for (int i = 0; i < 6; i++)
      for (int k = 0; k < 4; k++)
        run_op(ops[k], va[i], vb[i]);
  endtask

  task automatic shift_ops();
    logic [3:0]  ops [4] = '{alu_pkg::OP_SLA, alu_pkg::OP_SRA, alu_pkg::OP_SLL, alu_pkg::OP_SRL};
    logic [15:0] va [6] = '{16'h0001, 16'h4000, 16'hC000, 16'h8001, 16'hFFFF, 16'h1234};
    logic [15:0] amts [5] = '{16'd0, 16'd1, 16'd15, 16'd16, 16'd300};
    for (int i = 0; i < 6; i++)
      for (int j = 0; j < 5; j++)
        for (int k = 0; k < 4; k++)
          run_op(ops[k], va[i], amts[j]);
  endtask

  task automatic zero_flag();
    for (int i = 0; i < 4; i++) begin
      run_op(alu_pkg::OP_SUB, edge_vals[i], edge_vals[i]);
      check_eq("status.zero", rdata[17], 1'b1);
    end
    for (int op = 12; op < 16; op++) begin
      run_op(op[3:0], 16'h1234, 16'h00FF);
      check_eq("status.zero", rdata[17], 1'b1);
    end
    run_op(alu_pkg::OP_ADD, 16'h0001, 16'h0002);
    check_eq("status.zero", rdata[17], 1'b0);
  endtask

  task automatic error_responses();
    run_op(alu_pkg::OP_ADD, 16'h1111, 16'h2222);
    apb_read(8'h10);
    check_eq("pslverr unmapped", rerr, 1'b1);
    check_eq("prdata unmapped", rdata, 32'h0);
    apb_read(8'h02);
    check_eq("pslverr misaligned", rerr, 1'b1);
    apb_write(`ALU_REG_STATUS, 32'hFFFF_FFFF);
    check_eq("pslverr status write", rerr, 1'b1);
    apb_read(`ALU_REG_A);
    check_eq("reg a", rdata, 32'h1111);
    apb_read(`ALU_REG_B);
    check_eq("reg b", rdata, 32'h2222);
    apb_read(`ALU_REG_CTRL);
    check_eq("reg ctrl", rdata, 32'h1);
    apb_read(`ALU_REG_STATUS);
    // Valid sum 0x3333 with both flags clear
    check_eq("reg status", rdata, 32'h8000_3333);
  endtask

  initial begin
    arst_n  = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    void'($urandom(32'hc79dbeda));
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    reset_and_valid();
    arith_ops();
    logic_and_compare();
    shift_ops();
    zero_flag();
    error_responses();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/alu_apb_top.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_apb_top (
  input  wire                    clk,
  input  wire                    arst_n,
  input  wire [`ALU_APB_AW-1:0]  paddr,
  input  wire                    psel,
  input  wire                    penable,
  input  wire                    pwrite,
  input  wire [`ALU_APB_DW-1:0]  pwdata,
  output logic [`ALU_APB_DW-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr
);

  alu_pkg::alu_word_t operand_a;
  alu_pkg::alu_word_t operand_b;
  alu_pkg::alu_op_e   op;
  alu_pkg::alu_word_t arith_result;
  logic               arith_ovf;
  alu_pkg::alu_word_t ls_result;
  logic               ls_ovf;
  alu_pkg::alu_word_t result;
  logic               overflow;
  logic               zero;

  ////////////////////////////////////////////////////////////////////////////
  // Register block
  ////////////////////////////////////////////////////////////////////////////

  alu_apb_regs u_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .result    (result),
    .overflow  (overflow),
    .zero      (zero),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .op        (op)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  alu_arith_unit u_arith (
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .op           (op),
    .arith_result (arith_result),
    .arith_ovf    (arith_ovf)
  );

  alu_logic_shift_unit u_logic_shift (
    .operand_a (operand_a),
    .operand_b (operand_b),
    .op        (op),
    .ls_result (ls_result),
    .ls_ovf    (ls_ovf)
  );

  alu_result_select u_select (
    .op           (op),
    .arith_result (arith_result),
    .arith_ovf    (arith_ovf),
    .ls_result    (ls_result),
    .ls_ovf       (ls_ovf),
    .result       (result),
    .overflow     (overflow),
    .zero         (zero)
  );

endmodule

`default_nettype wire

/* hw/alu_apb_regs.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_apb_regs (
  input  wire                     clk,
  input  wire                     arst_n,
  input  wire [`ALU_APB_AW-1:0]   paddr,
  input  wire                     psel,
  input  wire                     penable,
  input  wire                     pwrite,
  input  wire [`ALU_APB_DW-1:0]   pwdata,
  input  wire alu_pkg::alu_word_t result,
  input  wire                     overflow,
  input  wire                     zero,
  output logic [`ALU_APB_DW-1:0]  prdata,
  output logic                    pready,
  output logic                    pslverr,
  output alu_pkg::alu_word_t      operand_a,
  output alu_pkg::alu_word_t      operand_b,
  output alu_pkg::alu_op_e        op
);

  localparam int unsigned PAD_W = `ALU_APB_DW - `ALU_DATA_W;

  logic                  access;
  logic [`ALU_APB_AW-1:0] addr_word;
  logic                  sel_a;
  logic                  sel_b;
  logic                  sel_ctrl;
  logic                  sel_status;
  logic                  misaligned;
  logic                  err;
  logic                  wr_en;
  logic                  capture_q;
  alu_pkg::alu_status_t  status_q;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  assign access    = psel & penable;
  assign addr_word = {paddr[`ALU_APB_AW-1:2], 2'b00};

  assign sel_a      = (addr_word == `ALU_REG_A);
  assign sel_b      = (addr_word == `ALU_REG_B);
  assign sel_ctrl   = (addr_word == `ALU_REG_CTRL);
  assign sel_status = (addr_word == `ALU_REG_STATUS);
  assign misaligned = |paddr[1:0];

  // STATUS is read only
  assign err = misaligned | ~(sel_a | sel_b | sel_ctrl | sel_status) | (pwrite & sel_status);

  assign wr_en   = access & pwrite & ~err;
  assign pready  = access;
  assign pslverr = access & err;

  // Read data only in a good read access phase
  always_comb begin
    prdata = '0;
    if (access && !pwrite && !err) begin
      if (sel_a)
        prdata = {{PAD_W{1'b0}}, operand_a};
      else if (sel_b)
        prdata = {{PAD_W{1'b0}}, operand_b};
      else if (sel_ctrl)
        prdata = {{(`ALU_APB_DW-`ALU_OP_W){1'b0}}, op};
      else
        prdata = status_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      operand_a <= '0;
      operand_b <= '0;
      op        <= alu_pkg::OP_SUB;
      capture_q <= 1'b0;
      status_q  <= '0;
    end else begin
      // Result is captured the cycle after the CTRL write
      capture_q <= wr_en & sel_ctrl;

      if (wr_en && sel_a)
        operand_a <= pwdata[`ALU_DATA_W-1:0];
      if (wr_en && sel_b)
        operand_b <= pwdata[`ALU_DATA_W-1:0];
      if (wr_en && sel_ctrl)
        op <= alu_pkg::alu_op_e'(pwdata[`ALU_OP_W-1:0]);

      // New operands make the old result stale
      if (wr_en && (sel_a || sel_b)) begin
        status_q.valid <= 1'b0;
      end else if (capture_q) begin
        status_q.valid    <= 1'b1;
        status_q.zero     <= zero;
        status_q.overflow <= overflow;
        status_q.result   <= result;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/alu_result_select.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_result_select (
  input  wire alu_pkg::alu_op_e   op,
  input  wire alu_pkg::alu_word_t arith_result,
  input  wire                     arith_ovf,
  input  wire alu_pkg::alu_word_t ls_result,
  input  wire                     ls_ovf,
  output alu_pkg::alu_word_t      result,
  output logic                    overflow,
  output logic                    zero
);

  ////////////////////////////////////////////////////////////////////////////
  // Unit select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (alu_pkg::is_arith_op(op)) begin
      result   = arith_result;
      overflow = arith_ovf;
    end else if (alu_pkg::is_logic_shift_op(op)) begin
      result   = ls_result;
      overflow = ls_ovf;
    end else begin
      // Opcodes 12 to 15
      result   = '0;
      overflow = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Zero flag
  ////////////////////////////////////////////////////////////////////////////

  assign zero = (result == {`ALU_DATA_W{1'b0}});

endmodule

`default_nettype wire

/* hw/alu_logic_shift_unit.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_logic_shift_unit (
  input  wire alu_pkg::alu_word_t operand_a,
  input  wire alu_pkg::alu_word_t operand_b,
  input  wire alu_pkg::alu_op_e   op,
  output alu_pkg::alu_word_t      ls_result,
  output logic                    ls_ovf
);

  // Shift amount is the full unsigned b word
  logic [`ALU_DATA_W-1:0] shamt;
  alu_pkg::alu_word_t     sla_res;
  alu_pkg::alu_word_t     sla_back;
  logic                   sla_ovf;

  assign shamt = operand_b;

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic left shift overflow
  ////////////////////////////////////////////////////////////////////////////

  assign sla_res  = operand_a <<< shamt;

  // Shifting back recovers a only if a * 2^b fits
  assign sla_back = sla_res >>> shamt;
  assign sla_ovf  = (sla_back != operand_a);

  always_comb begin
    ls_result = '0;
    ls_ovf    = 1'b0;
    case (op)
      alu_pkg::OP_OR:  ls_result = operand_a | operand_b;
      alu_pkg::OP_AND: ls_result = operand_a & operand_b;
      alu_pkg::OP_INV: ls_result = ~operand_a;
      alu_pkg::OP_SLA: begin
        ls_result = sla_res;
        ls_ovf    = sla_ovf;
      end
      // Sign fill on large amounts comes from the signed operand
      alu_pkg::OP_SRA: ls_result = operand_a >>> shamt;
      alu_pkg::OP_SLL: ls_result = operand_a << shamt;
      alu_pkg::OP_SRL: ls_result = $unsigned(operand_a) >> shamt;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hw/alu_arith_unit.sv */
`default_nettype none

`include "alu_settings.svh"

module alu_arith_unit (
  input  wire alu_pkg::alu_word_t operand_a,
  input  wire alu_pkg::alu_word_t operand_b,
  input  wire alu_pkg::alu_op_e   op,
  output alu_pkg::alu_word_t      arith_result,
  output logic                    arith_ovf
);

  localparam int unsigned MSB = `ALU_DATA_W - 1;
  localparam alu_pkg::alu_word_t ONE = 1;

  alu_pkg::alu_word_t sub_res;
  alu_pkg::alu_word_t add_res;
  alu_pkg::alu_word_t dec_res;
  alu_pkg::alu_word_t inc_res;
  logic               sub_ovf;
  logic               add_ovf;
  logic               dec_ovf;
  logic               inc_ovf;
  logic               le;

  ////////////////////////////////////////////////////////////////////////////
  // Wrapping results
  ////////////////////////////////////////////////////////////////////////////

  assign sub_res = operand_a - operand_b;
  assign add_res = operand_a + operand_b;
  assign dec_res = operand_a - ONE;
  assign inc_res = operand_a + ONE;

  // Signed compare of the two operand words
  assign le = (operand_a <= operand_b);

  ////////////////////////////////////////////////////////////////////////////
  // Signed overflow
  ////////////////////////////////////////////////////////////////////////////

  // Operand signs differ and the result flips away from a
  assign sub_ovf = (operand_a[MSB] != operand_b[MSB]) && (sub_res[MSB] != operand_a[MSB]);

  // Same operand signs but result sign differs
  assign add_ovf = (operand_a[MSB] == operand_b[MSB]) && (add_res[MSB] != operand_a[MSB]);

  // Only the most negative value wraps on decrement
  assign dec_ovf = operand_a[MSB] & ~dec_res[MSB];
  assign inc_ovf = ~operand_a[MSB] & inc_res[MSB];

  always_comb begin
    arith_result = '0;
    arith_ovf    = 1'b0;
    case (op)
      alu_pkg::OP_SUB: begin
        arith_result = sub_res;
        arith_ovf    = sub_ovf;
      end
      alu_pkg::OP_ADD: begin
        arith_result = add_res;
        arith_ovf    = add_ovf;
      end
      alu_pkg::OP_DEC: begin
        arith_result = dec_res;
        arith_ovf    = dec_ovf;
      end
      alu_pkg::OP_INC: begin
        arith_result = inc_res;
        arith_ovf    = inc_ovf;
      end
      alu_pkg::OP_SLE: arith_result = {{(`ALU_DATA_W-1){1'b0}}, le};
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hw/alu_pkg.sv */
`default_nettype none

`include "alu_settings.svh"

package alu_pkg;

  // Opcode encoding of the CTRL register
  typedef enum logic [`ALU_OP_W-1:0] {
    OP_SUB = 0,
    OP_ADD = 1,
    OP_OR  = 2,
    OP_AND = 3,
    OP_DEC = 4,
    OP_INC = 5,
    OP_INV = 6,
    OP_SLA = 7,
    OP_SRA = 8,
    OP_SLL = 9,
    OP_SRL = 10,
    OP_SLE = 11
  } alu_op_e;

  typedef logic signed [`ALU_DATA_W-1:0] alu_word_t;

  // STATUS register layout from the MSB down
  typedef struct packed {
    logic                                  valid;
    logic [`ALU_APB_DW-`ALU_DATA_W-4:0]    rsvd;
    logic                                  zero;
    logic                                  overflow;
    alu_word_t                             result;
  } alu_status_t;

  function automatic logic is_arith_op(input alu_op_e op);
    return op inside {OP_SUB, OP_ADD, OP_DEC, OP_INC, OP_SLE};
  endfunction

  function automatic logic is_logic_shift_op(input alu_op_e op);
    return op inside {OP_OR, OP_AND, OP_INV, OP_SLA, OP_SRA, OP_SLL, OP_SRL};
  endfunction

endpackage

`default_nettype wire

/* include/alu_settings.svh */
`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////////////////////

// Operand and result width
`define ALU_DATA_W 16
`define ALU_OP_W 4

////////////////////////////////////////////////////////////////////////////
// APB register port
////////////////////////////////////////////////////////////////////////////

`define ALU_APB_AW 8
`define ALU_APB_DW 32

// Byte offsets sized to the APB address width
`define ALU_REG_A 8'h00
`define ALU_REG_B 8'h04
`define ALU_REG_CTRL 8'h08
`define ALU_REG_STATUS 8'h0C

`endif
